/* hw/dmaPkg.sv */
// DMA datapath shared definitions

package dmaPkg;

  // Fixed by the 8237 register map and the byte pointer
  localparam int chanCount = 4;

  typedef logic [15:0] wordT;
  typedef logic [7:0] byteT;
  typedef logic [1:0] chanT;
  typedef logic [chanCount-1:0] chanMaskT;

  // One decoded CPU access per cycle
  typedef enum logic [3:0] {
    cmdNone,
    cmdWrAddr,
    cmdWrCount,
    cmdRdAddr,
    cmdRdCount,
    cmdRdStatus,
    cmdWrMode,
    cmdWrSingleMask,
    cmdWrAllMask,
    cmdClearPtr,
    cmdMasterClear,
    cmdClearMask
  } regCmdE;

  // Ports 0 to 7 are the channel registers
  localparam logic [3:0] portStatus      = 4'd8;
  localparam logic [3:0] portSingleMask  = 4'd10;
  localparam logic [3:0] portMode        = 4'd11;
  localparam logic [3:0] portClearPtr    = 4'd12;
  localparam logic [3:0] portMasterClear = 4'd13;
  localparam logic [3:0] portClearMask   = 4'd14;
  localparam logic [3:0] portAllMask     = 4'd15;

  // Mode and single-mask data fields
  localparam int modeChanLsb = 0;
  localparam int modeAutoBit = 4;
  localparam int modeDecBit  = 5;
  localparam int maskSetBit  = 2;

  // Replaces the low or high byte of a word
  function automatic wordT setByte(wordT word, logic high, byteT data);
    wordT result;
    result = word;
    if (high)
    begin
      result[15:8] = data;
    end
    else
    begin
      result[7:0] = data;
    end
    return result;
  endfunction

endpackage

/* hw/dmaRegDecode.sv */
// DMA register decoder

module dmaRegDecode
  import dmaPkg::*;
(
  input  logic     dif,
  input  logic     rstN,
  input  logic     csN,
  input  logic     iorN,
  input  logic     iowN,
  input  logic [3:0] addr,
  input  byteT     dataIn,
  input  logic     xferStep,
  input  chanT     xferChan,
  input  logic     wrapNow,
  output regCmdE   cmd,
  output chanT     cmdChan,
  output logic     cmdHigh,
  output byteT     wrByte,
  output logic     stepGo,
  output chanT     stepChan,
  output chanMaskT autoInit,
  output chanMaskT addrDown,
  output logic     clearAll
);

  logic     rdAcc;
  logic     wrAcc;
  logic     bytePtr;
  chanMaskT mask;
  chanMaskT maskNext;
  chanT     modeChan;

  assign rdAcc = !csN && !iorN && iowN;
  assign wrAcc = !csN && !iowN && iorN;

  // Bus access to command
  always_comb
  begin
    cmd = cmdNone;
    if (rdAcc)
    begin
      if (!addr[3])
      begin
        if (addr[0])
          cmd = cmdRdCount;
        else
          cmd = cmdRdAddr;
      end
      else if (addr == portStatus)
      begin
        cmd = cmdRdStatus;
      end
    end
    else if (wrAcc)
    begin
      if (!addr[3])
      begin
        if (addr[0])
          cmd = cmdWrCount;
        else
          cmd = cmdWrAddr;
      end
      else
      begin
        case (addr)
          portSingleMask:  cmd = cmdWrSingleMask;
          portMode:        cmd = cmdWrMode;
          portClearPtr:    cmd = cmdClearPtr;
          portMasterClear: cmd = cmdMasterClear;
          portClearMask:   cmd = cmdClearMask;
          portAllMask:     cmd = cmdWrAllMask;
          default:         cmd = cmdNone;
        endcase
      end
    end
  end

  assign cmdChan  = addr[2:1];
  assign cmdHigh  = bytePtr;
  assign wrByte   = dataIn;
  assign clearAll = (cmd == cmdMasterClear);
  assign modeChan = dataIn[modeChanLsb +: 2];

  // Masked channels ignore the step
  assign stepGo   = xferStep && !mask[xferChan];
  assign stepChan = xferChan;

  // Byte pointer flips on every channel register access
  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll || cmd == cmdClearPtr)
      bytePtr <= 1'b0;
    else if (cmd inside {cmdWrAddr, cmdWrCount, cmdRdAddr, cmdRdCount})
      bytePtr <= !bytePtr;
  end

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
    begin
      autoInit <= '0;
      addrDown <= '0;
    end
    else if (cmd == cmdWrMode)
    begin
      autoInit[modeChan] <= dataIn[modeAutoBit];
      addrDown[modeChan] <= dataIn[modeDecBit];
    end
  end

  // Terminal count without autoinit masks the channel, and wins over a command
  always_comb
  begin
    maskNext = mask;
    case (cmd)
      cmdWrSingleMask: maskNext[dataIn[1:0]] = dataIn[maskSetBit];
      cmdWrAllMask:    maskNext = dataIn[chanCount-1:0];
      cmdClearMask:    maskNext = '0;
      default:         maskNext = mask;
    endcase
    if (wrapNow && !autoInit[stepChan])
      maskNext[stepChan] = 1'b1;
  end

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
      mask <= '1;
    else
      mask <= maskNext;
  end

  assert property (@(posedge dif) disable iff (!rstN) !csN |-> (iorN || iowN))
    else $error("Read and write strobes both active");

endmodule

/* hw/dmaAddrBank.sv */
// DMA address register bank

module dmaAddrBank
  import dmaPkg::*;
(
  input  logic     dif,
  input  logic     rstN,
  input  logic     clearAll,
  input  regCmdE   cmd,
  input  chanT     cmdChan,
  input  logic     cmdHigh,
  input  byteT     wrByte,
  input  logic     stepGo,
  input  chanT     stepChan,
  input  logic     wrapNow,
  input  chanMaskT autoInit,
  input  chanMaskT addrDown,
  output wordT     rdAddr,
  output wordT     stepAddr
);

  wordT baseAddr [chanCount];
  wordT currAddr [chanCount];

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
    begin
      for (int i = 0; i < chanCount; i++)
      begin
        baseAddr[i] <= '0;
        currAddr[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < chanCount; i++)
      begin
        // CPU write loads base and current together
        if (cmd == cmdWrAddr && cmdChan == chanT'(i))
        begin
          baseAddr[i] <= setByte(baseAddr[i], cmdHigh, wrByte);
          currAddr[i] <= setByte(currAddr[i], cmdHigh, wrByte);
        end
        else if (stepGo && stepChan == chanT'(i))
        begin
          if (wrapNow && autoInit[i])
            currAddr[i] <= baseAddr[i];
          else if (addrDown[i])
            currAddr[i] <= currAddr[i] - 16'd1;
          else
            currAddr[i] <= currAddr[i] + 16'd1;
        end
      end
    end
  end

  // Readback for the CPU and the pre-step address for the transfer
  assign rdAddr   = currAddr[cmdChan];
  assign stepAddr = currAddr[stepChan];

  assert property (@(posedge dif) disable iff (!rstN)
    !(stepGo && cmd == cmdWrAddr && cmdChan == stepChan))
    else $error("Step and address write hit the same channel");

endmodule

/* hw/dmaCountBank.sv */
// DMA word count register bank

module dmaCountBank
  import dmaPkg::*;
(
  input  logic     dif,
  input  logic     rstN,
  input  logic     clearAll,
  input  regCmdE   cmd,
  input  chanT     cmdChan,
  input  logic     cmdHigh,
  input  byteT     wrByte,
  input  logic     stepGo,
  input  chanT     stepChan,
  input  chanMaskT autoInit,
  output wordT     rdCount,
  output logic     wrapNow
);

  wordT baseCount [chanCount];
  wordT currCount [chanCount];
  logic countZero;

  // Terminal count is the step that takes zero to all ones
  assign countZero = (currCount[stepChan] == '0);
  assign wrapNow   = stepGo && countZero;

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
    begin
      for (int i = 0; i < chanCount; i++)
      begin
        baseCount[i] <= '0;
        currCount[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < chanCount; i++)
      begin
        if (cmd == cmdWrCount && cmdChan == chanT'(i))
        begin
          baseCount[i] <= setByte(baseCount[i], cmdHigh, wrByte);
          currCount[i] <= setByte(currCount[i], cmdHigh, wrByte);
        end
        else if (stepGo && stepChan == chanT'(i))
        begin
          // Autoinit restarts from base, otherwise wrap to all ones
          if (wrapNow && autoInit[i])
            currCount[i] <= baseCount[i];
          else
            currCount[i] <= currCount[i] - 16'd1;
        end
      end
    end
  end

  assign rdCount = currCount[cmdChan];

  assert property (@(posedge dif) disable iff (!rstN)
    !(stepGo && cmd == cmdWrCount && cmdChan == stepChan))
    else $error("Step and count write hit the same channel");

endmodule

/* hw/dmaReadPort.sv */
// DMA read data and transfer result port

module dmaReadPort
  import dmaPkg::*;
(
  input  logic   dif,
  input  logic   rstN,
  input  logic   clearAll,
  input  regCmdE cmd,
  input  logic   cmdHigh,
  input  wordT   rdAddr,
  input  wordT   rdCount,
  input  logic   stepGo,
  input  chanT   stepChan,
  input  wordT   stepAddr,
  input  logic   wrapNow,
  output byteT   dataOut,
  output logic   xferDone,
  output wordT   xferAddr,
  output logic   eop
);

  chanMaskT tcBits;
  chanMaskT tcClear;
  chanMaskT tcSet;

  // A status read clears what it returned, a wrap in the same cycle still sets
  assign tcClear = (cmd == cmdRdStatus) ? tcBits : '0;
  assign tcSet   = wrapNow ? chanMaskT'(1 << stepChan) : '0;

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
      tcBits <= '0;
    else
      tcBits <= (tcBits & ~tcClear) | tcSet;
  end

  // Read data holds until the next read
  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
      dataOut <= '0;
    else
    begin
      case (cmd)
        cmdRdAddr:   dataOut <= cmdHigh ? rdAddr[15:8] : rdAddr[7:0];
        cmdRdCount:  dataOut <= cmdHigh ? rdCount[15:8] : rdCount[7:0];
        cmdRdStatus: dataOut <= {{(8 - chanCount){1'b0}}, tcBits};
        default:     dataOut <= dataOut;
      endcase
    end
  end

  always_ff @(posedge dif)
  begin
    if (!rstN || clearAll)
    begin
      xferDone <= 1'b0;
      eop      <= 1'b0;
    end
    else
    begin
      xferDone <= stepGo;
      eop      <= wrapNow;
    end
  end

  // Address before the step
  always_ff @(posedge dif)
  begin
    if (stepGo)
      xferAddr <= stepAddr;
  end

  assert property (@(posedge dif) disable iff (!rstN) eop |-> xferDone)
    else $error("End of process without a transfer");

endmodule

/* hw/dmaDatapath.sv */
// DMA register and address datapath

module dmaDatapath
  import dmaPkg::*;
(
  input  logic       dif,
  input  logic       rstN,
  input  logic       csN,
  input  logic       iorN,
  input  logic       iowN,
  input  logic [3:0] addr,
  input  byteT       dataIn,
  input  logic       xferStep,
  input  chanT       xferChan,
  output byteT       dataOut,
  output logic       xferDone,
  output wordT       xferAddr,
  output logic       eop
);

  regCmdE   cmd;
  chanT     cmdChan;
  logic     cmdHigh;
  byteT     wrByte;
  logic     stepGo;
  chanT     stepChan;
  chanMaskT autoInit;
  chanMaskT addrDown;
  logic     clearAll;
  logic     wrapNow;
  wordT     rdAddr;
  wordT     stepAddr;
  wordT     rdCount;

  // Bus decode, mode and mask
  dmaRegDecode dmaRegDecode_i (
    .dif      (dif),
    .rstN     (rstN),
    .csN      (csN),
    .iorN     (iorN),
    .iowN     (iowN),
    .addr     (addr),
    .dataIn   (dataIn),
    .xferStep (xferStep),
    .xferChan (xferChan),
    .wrapNow  (wrapNow),
    .cmd      (cmd),
    .cmdChan  (cmdChan),
    .cmdHigh  (cmdHigh),
    .wrByte   (wrByte),
    .stepGo   (stepGo),
    .stepChan (stepChan),
    .autoInit (autoInit),
    .addrDown (addrDown),
    .clearAll (clearAll)
  );

  dmaAddrBank dmaAddrBank_i (
    .dif      (dif),
    .rstN     (rstN),
    .clearAll (clearAll),
    .cmd      (cmd),
    .cmdChan  (cmdChan),
    .cmdHigh  (cmdHigh),
    .wrByte   (wrByte),
    .stepGo   (stepGo),
    .stepChan (stepChan),
    .wrapNow  (wrapNow),
    .autoInit (autoInit),
    .addrDown (addrDown),
    .rdAddr   (rdAddr),
    .stepAddr (stepAddr)
  );

  dmaCountBank dmaCountBank_i (
    .dif      (dif),
    .rstN     (rstN),
    .clearAll (clearAll),
    .cmd      (cmd),
    .cmdChan  (cmdChan),
    .cmdHigh  (cmdHigh),
    .wrByte   (wrByte),
    .stepGo   (stepGo),
    .stepChan (stepChan),
    .autoInit (autoInit),
    .rdCount  (rdCount),
    .wrapNow  (wrapNow)
  );

  dmaReadPort dmaReadPort_i (
    .dif      (dif),
    .rstN     (rstN),
    .clearAll (clearAll),
    .cmd      (cmd),
    .cmdHigh  (cmdHigh),
    .rdAddr   (rdAddr),
    .rdCount  (rdCount),
    .stepGo   (stepGo),
    .stepChan (stepChan),
    .stepAddr (stepAddr),
    .wrapNow  (wrapNow),
    .dataOut  (dataOut),
    .xferDone (xferDone),
    .xferAddr (xferAddr),
    .eop      (eop)
  );

endmodule

/* testbench/dmaTbTests.svh */
// DMA directed tests

task automatic programReadback();
  int   startErrors;
  wordT addrs [chanCount];
  wordT counts [chanCount];
  startErrors = errorCount;
  clearPointer();
  for (int ch = 0; ch < chanCount; ch++)
  begin
    addrs[ch] = randWord();
    counts[ch] = randWord();
    writeWord(addrPort(chanT'(ch)), addrs[ch]);
    writeWord(countPort(chanT'(ch)), counts[ch]);
  end
  for (int ch = 0; ch < chanCount; ch++)
  begin
    expectWord("programReadback", addrPort(chanT'(ch)), addrs[ch]);
    expectWord("programReadback", countPort(chanT'(ch)), counts[ch]);
  end
  finishTest("programReadback", startErrors);
endtask

task automatic pointerClear();
  int   startErrors;
  byteT low;
  byteT high;
  startErrors = errorCount;
  low = randByte();
  high = randByte();
  // Stray low byte leaves the pointer high
  writeReg(addrPort(2'd2), randByte());
  clearPointer();
  writeReg(addrPort(2'd2), low);
  writeReg(addrPort(2'd2), high);
  expectWord("pointerClear", addrPort(2'd2), {high, low});
  finishTest("pointerClear", startErrors);
endtask

task automatic steppingModes();
  int   startErrors;
  wordT base;
  startErrors = errorCount;
  base = randWord();
  setMode(2'd1, 1'b0, 1'b0);
  writeWord(addrPort(2'd1), base);
  writeWord(countPort(2'd1), 16'd10);
  setMask(2'd1, 1'b0);
  for (int i = 0; i < 3; i++)
    expectStep("steppingModes", 2'd1, base + 16'(i), 1'b0);
  // Same channel counting down
  base = randWord();
  setMode(2'd1, 1'b0, 1'b1);
  writeWord(addrPort(2'd1), base);
  for (int i = 0; i < 3; i++)
    expectStep("steppingModes", 2'd1, base - 16'(i), 1'b0);
  expectNoStep("steppingModes", 2'd2);
  finishTest("steppingModes", startErrors);
endtask

task automatic terminalCount();
  int   startErrors;
  wordT base;
  byteT status;
  startErrors = errorCount;
  base = randWord();
  setMode(2'd0, 1'b0, 1'b0);
  writeWord(addrPort(2'd0), base);
  writeWord(countPort(2'd0), 16'd1);
  setMask(2'd0, 1'b0);
  expectStep("terminalCount", 2'd0, base, 1'b0);
  expectStep("terminalCount", 2'd0, base + 16'd1, 1'b1);
  readReg(portStatus, status);
  checkByte("terminalCount", 8'h01, status);
  readReg(portStatus, status);
  checkByte("terminalCount", 8'h00, status);
  // Channel masked itself at the wrap
  expectNoStep("terminalCount", 2'd0);
  expectWord("terminalCount", countPort(2'd0), 16'hFFFF);
  finishTest("terminalCount", startErrors);
endtask

task automatic autoInitReload();
  int   startErrors;
  wordT base;
  byteT status;
  startErrors = errorCount;
  base = randWord();
  setMode(2'd3, 1'b1, 1'b0);
  writeWord(addrPort(2'd3), base);
  writeWord(countPort(2'd3), 16'd2);
  setMask(2'd3, 1'b0);
  expectStep("autoInitReload", 2'd3, base, 1'b0);
  expectStep("autoInitReload", 2'd3, base + 16'd1, 1'b0);
  expectStep("autoInitReload", 2'd3, base + 16'd2, 1'b1);
  expectWord("autoInitReload", addrPort(2'd3), base);
  expectWord("autoInitReload", countPort(2'd3), 16'd2);
  readReg(portStatus, status);
  checkByte("autoInitReload", 8'h08, status);
  finishTest("autoInitReload", startErrors);
endtask

task automatic maskAndMasterClear();
  int   startErrors;
  logic done;
  wordT addrSeen;
  logic eopSeen;
  byteT status;
  startErrors = errorCount;
  writeReg(portClearMask, 8'h00);
  // Channel 0 masked itself earlier and is open again
  stepChannel(2'd0, done, addrSeen, eopSeen);
  checkFlag("maskAndMasterClear", 1'b1, done);
  // Zero count makes the channel 3 step wrap and leave a status bit
  writeWord(countPort(2'd3), 16'h0000);
  writeReg(portAllMask, 8'h05);
  // Only the odd channels are open
  for (int ch = 0; ch < chanCount; ch++)
  begin
    stepChannel(chanT'(ch), done, addrSeen, eopSeen);
    checkFlag("maskAndMasterClear", ch[0], done);
  end
  writeReg(portMasterClear, 8'h00);
  for (int ch = 0; ch < chanCount; ch++)
  begin
    expectWord("maskAndMasterClear", addrPort(chanT'(ch)), 16'h0000);
    expectWord("maskAndMasterClear", countPort(chanT'(ch)), 16'h0000);
  end
  readReg(portStatus, status);
  checkByte("maskAndMasterClear", 8'h00, status);
  for (int ch = 0; ch < chanCount; ch++)
    expectNoStep("maskAndMasterClear", chanT'(ch));
  finishTest("maskAndMasterClear", startErrors);
endtask

/* testbench/dmaTb.sv */
// DMA datapath testbench

module dmaTb
  import dmaPkg::*;
();

  localparam int stepTimeout = 8;

  logic       dif;
  logic       rstN;
  logic       csN;
  logic       iorN;
  logic       iowN;
  logic [3:0] addr;
  byteT       dataIn;
  logic       xferStep;
  chanT       xferChan;
  byteT       dataOut;
  logic       xferDone;
  wordT       xferAddr;
  logic       eop;

  logic [15:0] lfsrState;
  int          errorCount;
  int          checkCount;
  int          testCount;

  dmaDatapath dmaDatapath_i (
    .dif      (dif),
    .rstN     (rstN),
    .csN      (csN),
    .iorN     (iorN),
    .iowN     (iowN),
    .addr     (addr),
    .dataIn   (dataIn),
    .xferStep (xferStep),
    .xferChan (xferChan),
    .dataOut  (dataOut),
    .xferDone (xferDone),
    .xferAddr (xferAddr),
    .eop      (eop)
  );

  initial
  begin
    dif = 1'b0;
    forever #5 dif = ~dif;
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic byteT randByte();
    byteT value;
    value = '0;
    for (int i = 0; i < 8; i++)
      value = {value[6:0], lfsrBit()};
    return value;
  endfunction

  function automatic wordT randWord();
    byteT low;
    byteT high;
    low = randByte();
    high = randByte();
    return {high, low};
  endfunction

  // Channel register ports
  function automatic logic [3:0] addrPort(chanT ch);
    return {1'b0, ch, 1'b0};
  endfunction

  function automatic logic [3:0] countPort(chanT ch);
    return {1'b0, ch, 1'b1};
  endfunction

  task automatic checkByte(string name, byteT expected, byteT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic checkWord(string name, wordT expected, wordT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(string name, logic expected, logic actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error: %s expected %b actual %b", name, expected, actual);
    end
  endtask

  // One-cycle CPU accesses, driven between falling edges
  task automatic writeReg(logic [3:0] port, byteT data);
    @(negedge dif);
    csN = 1'b0;
    iowN = 1'b0;
    addr = port;
    dataIn = data;
    @(negedge dif);
    csN = 1'b1;
    iowN = 1'b1;
  endtask

  task automatic readReg(logic [3:0] port, output byteT data);
    @(negedge dif);
    csN = 1'b0;
    iorN = 1'b0;
    addr = port;
    @(negedge dif);
    csN = 1'b1;
    iorN = 1'b1;
    data = dataOut;
  endtask

  task automatic clearPointer();
    writeReg(portClearPtr, 8'h00);
  endtask

  task automatic writeWord(logic [3:0] port, wordT value);
    writeReg(port, value[7:0]);
    writeReg(port, value[15:8]);
  endtask

  // Pointer must be low here
  task automatic expectWord(string name, logic [3:0] port, wordT expected);
    byteT data;
    readReg(port, data);
    checkByte(name, expected[7:0], data);
    readReg(port, data);
    checkByte(name, expected[15:8], data);
  endtask

  task automatic setMode(chanT ch, logic auto, logic down);
    writeReg(portMode, {2'b00, down, auto, 2'b00, ch});
  endtask

  task automatic setMask(chanT ch, logic set);
    writeReg(portSingleMask, {5'b00000, set, ch});
  endtask

  // Pulse one step, then wait a bounded time for xferDone
  task automatic stepChannel(chanT ch, output logic done, output wordT addrSeen,
                             output logic eopSeen);
    @(negedge dif);
    xferStep = 1'b1;
    xferChan = ch;
    @(negedge dif);
    xferStep = 1'b0;
    done = 1'b0;
    addrSeen = '0;
    eopSeen = 1'b0;
    for (int i = 0; i < stepTimeout; i++)
    begin
      if (xferDone)
      begin
        done = 1'b1;
        addrSeen = xferAddr;
        eopSeen = eop;
        break;
      end
      @(negedge dif);
    end
  endtask

  task automatic expectStep(string name, chanT ch, wordT expAddr, logic expEop);
    logic done;
    wordT addrSeen;
    logic eopSeen;
    stepChannel(ch, done, addrSeen, eopSeen);
    if (!done)
    begin
      errorCount++;
      $display("Step on channel %0d in %s got no xferDone within %0d cycles",
               ch, name, stepTimeout);
    end
    else
    begin
      checkWord(name, expAddr, addrSeen);
      checkFlag(name, expEop, eopSeen);
    end
  endtask

  task automatic expectNoStep(string name, chanT ch);
    logic done;
    wordT addrSeen;
    logic eopSeen;
    stepChannel(ch, done, addrSeen, eopSeen);
    checkFlag(name, 1'b0, done);
  endtask

  task automatic finishTest(string name, int startErrors);
    testCount++;
    if (errorCount == startErrors)
      $display("Test %s ok", name);
    else
      $display("Test %s failed with %0d errors", name, errorCount - startErrors);
  endtask

  `include "dmaTbTests.svh"

  initial
  begin
    rstN = 1'b0;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    addr = '0;
    dataIn = '0;
    xferStep = 1'b0;
    xferChan = '0;
    lfsrState = 16'd98;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    repeat (8) @(posedge dif);
    @(negedge dif);
    rstN = 1'b1;

    programReadback();
    pointerClear();
    steppingModes();
    terminalCount();
    autoInitReload();
    maskAndMasterClear();

    $display("Ran %0d tests with %0d checks and %0d errors", testCount, checkCount,
             errorCount);
    if (errorCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* all.f */
+incdir+testbench
hw/dmaPkg.sv
hw/dmaRegDecode.sv
hw/dmaAddrBank.sv
hw/dmaCountBank.sv
hw/dmaReadPort.sv
hw/dmaDatapath.sv
testbench/dmaTb.sv

/* run.sh */
#!/bin/sh
# Builds the DMA datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dmaTb -Mdir obj_dir -o dmaSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/dmaSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
